//--- jtframe.f
+incdir+source
source/jtframe_pkg.sv
source/jtframe_hps_io.sv
source/jtframe_reset.sv
source/jtframe_joysticks.sv
source/jtframe_dip.sv
source/jtframe_video.sv
source/jtframe_mister.sv
tests/jtframe_sva.sv
tests/jtframe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the jtframe testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f jtframe.f --top-module jtframe_tb -o jtframe_sim

# A high error limit lets the run reach its summary line
./obj_dir/jtframe_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Testbench reported a failure, see sim.log"
    exit 1
fi
echo "Run finished without failures"

//--- source/jtframe_cfg.svh
`ifndef JTFRAME_CFG_SVH
`define JTFRAME_CFG_SVH

// Host command bytes
`define JTFRAME_CMD_STATUS      8'h1E
`define JTFRAME_CMD_JOY0        8'h02
`define JTFRAME_CMD_JOY1        8'h03
`define JTFRAME_CMD_DL_CTRL     8'h15
`define JTFRAME_CMD_DL_DATA     8'h16

// Cycles a reset stays up after its last cause
`define JTFRAME_RST_CYCLES      16

// Game side input polarity
`define JTFRAME_INPUTS_ACTIVE_LOW   1

// Games with three fire buttons mask button 4
`define JTFRAME_THREE_BUTTONS   0

`endif

//--- source/jtframe_dip.sv
`default_nettype none
`timescale 1ns/100ps

module jtframe_dip(
    input  wire                  clk_sys,
    input  wire                  rst_n,
    input  wire jtframe_pkg::status_u status,
    output logic                 osd_reset,
    output logic                 dip_flip,
    output logic                 dip_test,
    output logic                 dip_pause,
    output logic [1:0]           dip_fxlevel,
    output logic                 enable_fm,
    output logic                 enable_psg,
    output logic [1:0]           rotate,
    output logic [7:0]           hdmi_arx,
    output logic [7:0]           hdmi_ary
);

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        osd_reset   <= 1'b0;
        dip_flip    <= 1'b0;
        dip_test    <= 1'b0;
        dip_pause   <= 1'b0;
        dip_fxlevel <= 2'd0;
        enable_fm   <= 1'b1;    // Matches an all zero status
        enable_psg  <= 1'b1;
        rotate      <= 2'd0;
        hdmi_arx    <= 8'd4;
        hdmi_ary    <= 8'd3;
    end else begin
        osd_reset   <= status.fields.osd_reset;
        dip_flip    <= status.fields.flip;
        dip_test    <= status.fields.test;
        dip_pause   <= status.fields.pause;
        dip_fxlevel <= status.fields.fxlevel;
        enable_fm   <= ~status.fields.fm_off;
        enable_psg  <= ~status.fields.psg_off;
        rotate      <= {status.fields.flip, status.fields.rotate};
        case (status.fields.aspect)
            2'd0:    {hdmi_arx, hdmi_ary} <= {8'd4,  8'd3};
            2'd1:    {hdmi_arx, hdmi_ary} <= {8'd16, 8'd9};
            2'd2:    {hdmi_arx, hdmi_ary} <= {8'd3,  8'd4};  // Vertical screen
            default: {hdmi_arx, hdmi_ary} <= {8'd16, 8'd10};
        endcase
    end
end

endmodule

`default_nettype wire

//--- source/jtframe_hps_io.sv
`default_nettype none
`timescale 1ns/100ps

`include "jtframe_cfg.svh"

module jtframe_hps_io(
    input  wire                  clk_sys,
    input  wire                  rst_n,
    // host bus
    input  wire  [ 7:0]          hps_data,
    input  wire                  hps_cmd,
    input  wire                  hps_strobe,
    // decoded settings
    output jtframe_pkg::status_u status,
    output logic [15:0]          joystick1,
    output logic [15:0]          joystick2,
    // ROM load
    output logic                 downloading,
    output logic                 ioctl_wr,
    output logic [21:0]          ioctl_addr,
    output logic [ 7:0]          ioctl_data
);

logic [ 7:0] cmd;       // Current command
logic [ 1:0] byte_cnt;  // Payload byte index
logic [23:0] shadow;    // Low bytes of the word being assembled

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        cmd      <= 8'd0;
        byte_cnt <= 2'd0;
    end else if (hps_cmd) begin
        cmd      <= hps_data;
        byte_cnt <= 2'd0;
    end else if (hps_strobe) begin
        byte_cnt <= byte_cnt + 2'd1;
    end
end

// Payload capture
always_ff @(posedge clk_sys) begin
    if (hps_strobe) begin
        case (byte_cnt)
            2'd0:    shadow[ 7: 0] <= hps_data;
            2'd1:    shadow[15: 8] <= hps_data;
            2'd2:    shadow[23:16] <= hps_data;
            default: ;  // Last status byte goes straight to status
        endcase
        if (cmd == `JTFRAME_CMD_DL_DATA) begin
            ioctl_data <= hps_data;
        end
    end
end

// A word is committed when its last byte arrives
always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        status      <= '0;
        joystick1   <= 16'd0;
        joystick2   <= 16'd0;
        downloading <= 1'b0;
        ioctl_wr    <= 1'b0;
        ioctl_addr  <= 22'd0;
    end else begin
        ioctl_wr <= 1'b0;
        if (ioctl_wr) begin
            ioctl_addr <= ioctl_addr + 22'd1;   // Next byte address
        end
        if (hps_strobe) begin
            case (cmd)
                `JTFRAME_CMD_STATUS: begin
                    if (byte_cnt == 2'd3) begin
                        status.raw <= {hps_data, shadow};
                    end
                end
                `JTFRAME_CMD_JOY0: begin
                    if (byte_cnt == 2'd1) begin
                        joystick1 <= {hps_data, shadow[7:0]};
                    end
                end
                `JTFRAME_CMD_JOY1: begin
                    if (byte_cnt == 2'd1) begin
                        joystick2 <= {hps_data, shadow[7:0]};
                    end
                end
                `JTFRAME_CMD_DL_CTRL: begin
                    downloading <= hps_data != 8'd0;
                    if (hps_data != 8'd0) begin
                        ioctl_addr <= 22'd0;    // New file starts at zero
                    end
                end
                `JTFRAME_CMD_DL_DATA: begin
                    ioctl_wr <= downloading;    // Data outside a download is dropped
                end
                default: ;
            endcase
        end
    end
end

endmodule

`default_nettype wire

//--- source/jtframe_joysticks.sv
`default_nettype none
`timescale 1ns/100ps

`include "jtframe_cfg.svh"

module jtframe_joysticks #(
    parameter THREE_BUTTONS = `JTFRAME_THREE_BUTTONS
)(
    input  wire         clk_sys,
    input  wire         rst_n,
    input  wire         game_rst,
    input  wire  [15:0] joystick1,
    input  wire  [15:0] joystick2,
    output logic [ 9:0] game_joystick1,
    output logic [ 9:0] game_joystick2,
    output logic [ 1:0] game_coin,
    output logic [ 1:0] game_start,
    output logic        game_service
);

import jtframe_pkg::*;

localparam logic INV = 1'(`JTFRAME_INPUTS_ACTIVE_LOW);

// Board word to game layout in active high
function automatic logic [9:0] game_map(input logic [15:0] joy);
    logic b4;
    b4 = THREE_BUTTONS != 0 ? 1'b0 : joy[JOY_B4];
    game_map = { 2'b00, b4, joy[JOY_B3], joy[JOY_B2], joy[JOY_B1],
                 joy[JOY_RIGHT], joy[JOY_LEFT], joy[JOY_DOWN], joy[JOY_UP] };
endfunction

always_ff @(posedge clk_sys) begin
    if (!rst_n || game_rst) begin   // Idle inputs while the game is held
        game_joystick1 <= {10{INV}};
        game_joystick2 <= {10{INV}};
        game_coin      <= {2{INV}};
        game_start     <= {2{INV}};
        game_service   <= INV;
    end else begin
        game_joystick1 <= game_map(joystick1) ^ {10{INV}};
        game_joystick2 <= game_map(joystick2) ^ {10{INV}};
        game_coin      <= {joystick2[JOY_COIN], joystick1[JOY_COIN]} ^ {2{INV}};
        game_start     <= {joystick2[JOY_START], joystick1[JOY_START]} ^ {2{INV}};
        game_service   <= (joystick1[JOY_SERVICE] | joystick2[JOY_SERVICE]) ^ INV;
    end
end

endmodule

`default_nettype wire

//--- source/jtframe_mister.sv
`default_nettype none
`timescale 1ns/100ps

`include "jtframe_cfg.svh"

module jtframe_mister #(
    parameter THREE_BUTTONS = `JTFRAME_THREE_BUTTONS
)(
    input  wire                  clk_sys,
    input  wire                  rst_n,
    input  wire                  pll_locked,
    // host bus
    input  wire  [ 7:0]          hps_data,
    input  wire                  hps_cmd,
    input  wire                  hps_strobe,
    output wire jtframe_pkg::status_u status,
    // ROM load
    output wire  [21:0]          ioctl_addr,
    output wire  [ 7:0]          ioctl_data,
    output wire                  ioctl_wr,
    output wire                  downloading,
    // resets
    input  wire                  rst_req,
    output wire                  rst,
    output wire                  game_rst,
    output wire                  game_rst_n,
    // game inputs
    output wire  [ 9:0]          game_joystick1,
    output wire  [ 9:0]          game_joystick2,
    output wire  [ 1:0]          game_coin,
    output wire  [ 1:0]          game_start,
    output wire                  game_service,
    // DIP and OSD settings
    output wire                  dip_flip,
    output wire                  dip_test,
    output wire                  dip_pause,
    output wire  [ 1:0]          dip_fxlevel,
    output wire                  enable_fm,
    output wire                  enable_psg,
    output wire  [ 1:0]          rotate,
    output wire  [ 7:0]          hdmi_arx,
    output wire  [ 7:0]          hdmi_ary,
    // game video
    input  wire                  pxl_cen,
    input  wire  [ 3:0]          game_r, game_g, game_b,
    input  wire                  LHBL,
    input  wire                  LVBL,
    input  wire                  hs,
    input  wire                  vs,
    // VGA and HDMI
    output wire  [ 5:0]          VGA_R, VGA_G, VGA_B,
    output wire                  VGA_HS,
    output wire                  VGA_VS,
    output wire  [ 7:0]          hdmi_r, hdmi_g, hdmi_b,
    output wire                  hdmi_hs,
    output wire                  hdmi_vs,
    output wire                  hdmi_de
);

wire [15:0] joystick1;      // Board joystick words
wire [15:0] joystick2;
wire        osd_reset;

// Port names match across blocks
jtframe_hps_io u_hps_io(.*);

jtframe_reset u_reset(.*);

jtframe_joysticks #(.THREE_BUTTONS(THREE_BUTTONS)) u_joysticks(.*);

jtframe_dip u_dip(.*);

jtframe_video u_video(.*);

endmodule

`default_nettype wire

//--- source/jtframe_pkg.sv
`default_nettype none

package jtframe_pkg;

    // OSD status word as set by the host
    typedef struct packed {
        logic [20:0] reserved;
        logic        rotate;
        logic [ 1:0] aspect;    // HDMI aspect ratio select
        logic        psg_off;
        logic        fm_off;
        logic [ 1:0] fxlevel;   // Scanline strength
        logic        pause;
        logic        test;
        logic        flip;
        logic        osd_reset;
    } status_fields_t;

    typedef union packed {
        logic [31:0]    raw;
        status_fields_t fields;
    } status_u;

    // Bit positions in the board joystick word
    localparam int JOY_UP      = 0;
    localparam int JOY_DOWN    = 1;
    localparam int JOY_LEFT    = 2;
    localparam int JOY_RIGHT   = 3;
    localparam int JOY_B1      = 4;
    localparam int JOY_B2      = 5;
    localparam int JOY_B3      = 6;
    localparam int JOY_B4      = 7;
    localparam int JOY_COIN    = 8;
    localparam int JOY_START   = 9;
    localparam int JOY_SERVICE = 10;

endpackage

`default_nettype wire

//--- source/jtframe_reset.sv
`default_nettype none
`timescale 1ns/100ps

`include "jtframe_cfg.svh"

module jtframe_reset(
    input  wire   clk_sys,
    input  wire   rst_n,
    input  wire   pll_locked,
    // game reset causes
    input  wire   downloading,
    input  wire   rst_req,
    input  wire   osd_reset,
    input  wire   dip_flip,
    output logic  rst,
    output logic  game_rst,
    output logic  game_rst_n
);

localparam int            CW   = $clog2(`JTFRAME_RST_CYCLES + 1);
localparam logic [CW-1:0] HOLD = CW'(`JTFRAME_RST_CYCLES);

logic          flip_r;
logic          flip_chg;
logic [1:0]    cause;   // 0 is system, 1 is game
logic [1:0]    hold;
logic [CW-1:0] cnt [2];

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        flip_r <= 1'b0;
    end else begin
        flip_r <= dip_flip;
    end
end

assign flip_chg = dip_flip != flip_r;   // Flipping the screen restarts the game
assign cause[0] = ~pll_locked;
assign cause[1] = hold[0] | downloading | rst_req | osd_reset | flip_chg;

// Each reset is held until its counter runs out
always_ff @(posedge clk_sys) begin
    for (int i = 0; i < 2; i++) begin
        if (!rst_n || cause[i]) begin
            cnt[i]  <= HOLD;
            hold[i] <= 1'b1;
        end else if (cnt[i] != '0) begin
            cnt[i]  <= cnt[i] - 1'b1;
        end else begin
            hold[i] <= 1'b0;
        end
    end
end

assign rst        = hold[0];
assign game_rst   = hold[1];
assign game_rst_n = ~hold[1];

endmodule

`default_nettype wire

//--- source/jtframe_video.sv
`default_nettype none
`timescale 1ns/100ps

module jtframe_video(
    input  wire         clk_sys,
    input  wire         rst_n,
    input  wire         pxl_cen,
    input  wire  [3:0]  game_r,
    input  wire  [3:0]  game_g,
    input  wire  [3:0]  game_b,
    input  wire         LHBL,
    input  wire         LVBL,
    input  wire         hs,
    input  wire         vs,
    input  wire  [1:0]  dip_fxlevel,
    output logic [5:0]  VGA_R,
    output logic [5:0]  VGA_G,
    output logic [5:0]  VGA_B,
    output logic        VGA_HS,
    output logic        VGA_VS,
    output logic [7:0]  hdmi_r,
    output logic [7:0]  hdmi_g,
    output logic [7:0]  hdmi_b,
    output logic        hdmi_hs,
    output logic        hdmi_vs,
    output logic        hdmi_de
);

logic hs_l;
logic line_odd;     // Scanline parity
logic active;

assign active = LHBL & LVBL;

function automatic logic [5:0] vga_col(input logic [3:0] c);
    vga_col = active ? {c, c[3:2]} : 6'd0;
endfunction

// Full depth colour dimmed on odd lines
function automatic logic [7:0] hdmi_col(input logic [3:0] c);
    logic [7:0] x;
    x = active ? {c, c} : 8'd0;
    if (line_odd) begin
        case (dip_fxlevel)
            2'd1:    x = x - (x >> 2);
            2'd2:    x = x - (x >> 1);
            2'd3:    x = x - (x >> 1) - (x >> 2);
            default: ;
        endcase
    end
    hdmi_col = x;
endfunction

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        hs_l     <= 1'b0;
        line_odd <= 1'b0;
    end else begin
        hs_l <= hs;
        if (vs) line_odd <= 1'b0;                       // Every frame starts even
        else if (hs && !hs_l) line_odd <= ~line_odd;
    end
end

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        {VGA_R, VGA_G, VGA_B, VGA_HS, VGA_VS} <= '0;
        {hdmi_r, hdmi_g, hdmi_b, hdmi_hs, hdmi_vs, hdmi_de} <= '0;
    end else if (pxl_cen) begin
        VGA_R   <= vga_col(game_r);
        VGA_G   <= vga_col(game_g);
        VGA_B   <= vga_col(game_b);
        VGA_HS  <= hs;
        VGA_VS  <= vs;
        hdmi_r  <= hdmi_col(game_r);
        hdmi_g  <= hdmi_col(game_g);
        hdmi_b  <= hdmi_col(game_b);
        hdmi_hs <= hs;
        hdmi_vs <= vs;
        hdmi_de <= active;
    end
end

endmodule

`default_nettype wire

//--- tests/jtframe_sva.sv
`default_nettype none
`timescale 1ns/100ps

module jtframe_sva(
    input wire       clk_sys,
    input wire       rst_n,
    input wire       rst,
    input wire       game_rst,
    input wire       downloading,
    input wire       ioctl_wr,
    input wire       hdmi_de,
    input wire [7:0] hdmi_r,
    input wire [7:0] hdmi_g,
    input wire [7:0] hdmi_b
);

int fails = 0;  // Count of failed assertions

// Both resets follow the board reset one clock later
a_reset: assert property (@(posedge clk_sys) !rst_n |=> rst && game_rst) else begin
    fails++;
    $error("rst or game_rst low after rst_n was low");
end

a_dl_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
        downloading |=> game_rst) else begin
    fails++;
    $error("game_rst low during a download");
end

a_wr_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ioctl_wr |=> !ioctl_wr) else begin
    fails++;
    $error("ioctl_wr high for two cycles");
end

a_video_idle: assert property (@(posedge clk_sys) !rst_n |=>
        !hdmi_de && hdmi_r == 8'd0 && hdmi_g == 8'd0 && hdmi_b == 8'd0) else begin
    fails++;
    $error("HDMI output active after reset");
end

endmodule

bind jtframe_mister jtframe_sva u_sva(
    .clk_sys(clk_sys), .rst_n(rst_n), .rst(rst), .game_rst(game_rst),
    .downloading(downloading), .ioctl_wr(ioctl_wr), .hdmi_de(hdmi_de),
    .hdmi_r(hdmi_r), .hdmi_g(hdmi_g), .hdmi_b(hdmi_b)
);

`default_nettype wire

//--- tests/jtframe_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "jtframe_cfg.svh"

module jtframe_tb;

import jtframe_pkg::*;

localparam int   N_DL   = 24;   // Bytes in the test download
localparam logic INV_IN = `JTFRAME_INPUTS_ACTIVE_LOW != 0;
// HDMI ratio for aspect values 0 to 3
localparam logic [15:0] ASPECT [4] = '{16'h0403, 16'h1009, 16'h0304, 16'h100A};

logic        clk_sys = 1'b0;
logic        rst_n, pll_locked, rst_req, hps_cmd, hps_strobe;
logic [7:0]  hps_data;
logic        pxl_cen, LHBL, LVBL, hs, vs;
logic [3:0]  game_r, game_g, game_b;
status_u     status;
logic [21:0] ioctl_addr;
logic [7:0]  ioctl_data, hdmi_arx, hdmi_ary, hdmi_r, hdmi_g, hdmi_b;
logic        ioctl_wr, downloading, rst, game_rst, game_rst_n, game_service;
logic [9:0]  game_joystick1, game_joystick2;
logic [1:0]  game_coin, game_start, dip_fxlevel, rotate;
logic        dip_flip, dip_test, dip_pause, enable_fm, enable_psg;
logic [5:0]  VGA_R, VGA_G, VGA_B;
logic        VGA_HS, VGA_VS, hdmi_hs, hdmi_vs, hdmi_de;
logic [31:0] seed = 32'd49;
logic [7:0]  dl_bytes [N_DL];
int          errors = 0;
int          timeouts = 0;
int          wr_count = 0;

jtframe_mister uut(.*);

always #10 clk_sys = ~clk_sys;

function automatic logic [31:0] next_random();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
endfunction

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
endtask

// Board word to game joystick after polarity
function automatic logic [9:0] game_inputs(input logic [15:0] j);
    logic [9:0] g;
    g = {2'b00, j[7:0]};
    if (`JTFRAME_THREE_BUTTONS != 0) begin
        g[7] = 1'b0;
    end
    return g ^ {10{INV_IN}};
endfunction

function automatic logic [7:0] hdmi_exp(input logic [3:0] c, input logic on,
                                        input logic [1:0] lvl, input logic odd);
    logic [7:0] x;
    logic [7:0] cut;
    x   = on ? {c, c} : 8'd0;
    cut = 8'd0;
    if (odd) begin
        case (lvl)
            2'd1:    cut = x >> 2;              // Quarter
            2'd2:    cut = x >> 1;
            2'd3:    cut = (x >> 1) + (x >> 2);
            default: ;
        endcase
    end
    return x - cut;
endfunction

// Pulse on the host bus and the idle gap the decoder needs
task automatic host_byte(input logic is_cmd, input logic [7:0] b);
    hps_data   = b;
    hps_cmd    = is_cmd;
    hps_strobe = !is_cmd;
    @(negedge clk_sys);
    hps_cmd    = 1'b0;
    hps_strobe = 1'b0;
    repeat (2) @(negedge clk_sys);
endtask

task automatic host_write(input logic [7:0] cmd, input logic [31:0] w, input int nbytes);
    host_byte(1'b1, cmd);
    for (int i = 0; i < nbytes; i++) begin
        host_byte(1'b0, w[8*i +: 8]);       // LSB first
    end
endtask

task automatic wait_game_run();
    int n = 0;
    while (game_rst && n < 200) begin
        @(negedge clk_sys);
        n++;
    end
    if (game_rst) begin
        timeouts++;
        $display("Timeout: game reset was never released");
    end else begin
        compare("game_rst_n", game_rst_n, 1'b1);
    end
endtask

// Frame start and one hs edge for an odd line
task automatic start_line(input logic odd);
    vs = 1'b1;
    @(negedge clk_sys);
    vs = 1'b0;
    hs = odd;
    @(negedge clk_sys);
    hs = 1'b0;
endtask

task automatic pixel(input logic [1:0] lvl, input logic [31:0] r, input logic odd);
    logic on;
    {game_r, game_g, game_b} = r[11:0];
    LHBL    = r[12] | r[13];
    LVBL    = r[14] | r[15];
    hs      = r[16];
    vs      = r[17];
    on      = LHBL & LVBL;
    pxl_cen = 1'b1;
    @(negedge clk_sys);
    pxl_cen = 1'b0;
    hs      = 1'b0;
    vs      = 1'b0;
    compare("hdmi_de", hdmi_de, on);
    compare("VGA_HS", VGA_HS, r[16]);
    compare("VGA_VS", VGA_VS, r[17]);
    compare("hdmi_hs", hdmi_hs, r[16]);
    compare("hdmi_vs", hdmi_vs, r[17]);
    compare("{VGA_R,VGA_G,VGA_B}", {VGA_R, VGA_G, VGA_B},
            on ? {r[11:8], r[11:10], r[7:4], r[7:6], r[3:0], r[3:2]} : 18'd0);
    compare("{hdmi_r,hdmi_g,hdmi_b}", {hdmi_r, hdmi_g, hdmi_b},
            {hdmi_exp(r[11:8], on, lvl, odd), hdmi_exp(r[7:4], on, lvl, odd),
             hdmi_exp(r[3:0], on, lvl, odd)});
endtask

// Every write pulse is matched against the byte sent for it
always @(negedge clk_sys) begin
    if (ioctl_wr) begin
        if (wr_count < N_DL) begin
            compare("ioctl_data", ioctl_data, dl_bytes[wr_count]);
            compare("ioctl_addr", ioctl_addr, wr_count);
        end
        wr_count++;
    end
end

initial begin
    logic [31:0] s, j1, j2, r;
    int n;
    {rst_n, pll_locked, rst_req, hps_cmd, hps_strobe, hps_data} = '0;
    {pxl_cen, LHBL, LVBL, hs, vs, game_r, game_g, game_b} = '0;
    repeat (8) @(negedge clk_sys);
    rst_n = 1'b1;
    repeat (3) @(negedge clk_sys);
    pll_locked = 1'b1;
    n = 0;
    while (rst && n < 100) begin
        @(negedge clk_sys);
        n++;
    end
    if (rst) begin
        timeouts++;
        $display("Timeout: system reset was never released");
    end
    assert (n >= `JTFRAME_RST_CYCLES) else begin
        errors++;
        $display("** Error: rst fell after 0x%h cycles, expected at least 0x%h",
                 n, `JTFRAME_RST_CYCLES);
    end
    compare("game_rst", game_rst, 1'b1);
    compare("game_rst_n", game_rst_n, 1'b0);
    compare("game_joystick1", game_joystick1, {10{INV_IN}});   // Idle while held
    wait_game_run();
    rst_req = 1'b1;
    @(negedge clk_sys);
    rst_req = 1'b0;
    compare("game_rst", game_rst, 1'b1);
    compare("game_rst_n", game_rst_n, 1'b0);

    for (int a = 0; a < 4; a++) begin
        r = next_random();
        s = (r & ~32'h0000_0301) | (32'(a) << 8);   // osd_reset kept off
        host_write(`JTFRAME_CMD_STATUS, s, 4);
        compare("status", status.raw, s);
        compare("dip_flip", dip_flip, s[1]);
        compare("dip_test", dip_test, s[2]);
        compare("dip_pause", dip_pause, s[3]);
        compare("dip_fxlevel", dip_fxlevel, s[5:4]);
        compare("enable_fm", enable_fm, !s[6]);
        compare("enable_psg", enable_psg, !s[7]);
        compare("rotate", rotate, {s[1], s[10]});
        compare("{hdmi_arx,hdmi_ary}", {hdmi_arx, hdmi_ary}, ASPECT[a]);
    end
    wait_game_run();
    host_write(`JTFRAME_CMD_STATUS, s ^ 32'h2, 4);  // Flip only
    compare("game_rst", game_rst, 1'b1);

    wait_game_run();
    host_write(`JTFRAME_CMD_DL_CTRL, next_random() | 32'h1, 1);
    compare("downloading", downloading, 1'b1);
    host_byte(1'b1, `JTFRAME_CMD_DL_DATA);
    for (int i = 0; i < N_DL; i++) begin
        r = next_random();
        dl_bytes[i] = r[7:0];
        host_byte(1'b0, dl_bytes[i]);
    end
    n = 0;
    while (wr_count < N_DL && n < 20) begin
        @(negedge clk_sys);
        n++;
    end
    compare("ioctl_wr pulses", wr_count, N_DL);
    host_write(`JTFRAME_CMD_DL_CTRL, 32'h0, 1);
    compare("downloading", downloading, 1'b0);

    wait_game_run();
    for (int k = 0; k < 6; k++) begin
        j1 = next_random();
        j2 = next_random();
        host_write(`JTFRAME_CMD_JOY0, j1, 2);
        host_write(`JTFRAME_CMD_JOY1, j2, 2);
        compare("game_joystick1", game_joystick1, game_inputs(j1[15:0]));
        compare("game_joystick2", game_joystick2, game_inputs(j2[15:0]));
        compare("game_coin", game_coin, {j2[8], j1[8]} ^ {2{INV_IN}});
        compare("game_start", game_start, {j2[9], j1[9]} ^ {2{INV_IN}});
        compare("game_service", game_service, (j1[10] | j2[10]) ^ INV_IN);
    end

    for (int lvl = 0; lvl < 4; lvl++) begin
        host_write(`JTFRAME_CMD_STATUS, 32'(lvl) << 4, 4);
        for (int k = 0; k < 8; k++) begin
            start_line(k[0]);
            pixel(2'(lvl), next_random(), k[0]);
        end
    end

    errors = errors + uut.u_sva.fails;
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire
